//--- include/sl3_rx_cfg.svh
// shared constants for the two-lane 64b/66b receive coding layer
// lane count is fixed at 2; the EOP and idle ordering relies on it
// CRC is plain CRC-32, no reflection and no final inversion
`ifndef SL3_RX_CFG_SVH
`define SL3_RX_CFG_SVH

// lanes and block widths
`define SL3_LANES        2
`define SL3_BLOCK_W      66
`define SL3_PAYLOAD_W    64
`define SL3_KEEP_W       8

// error-free timer, stable once the msb sets
`define SL3_ERR_CNT_BITS 10

// crc-32 polynomial and start value
`define SL3_CRC_POLY     32'h04C11DB7
`define SL3_CRC_SEED     32'hFFFFFFFF

// control block type nibble
`define SL3_CTRL_IDLE    4'b0000
`define SL3_CTRL_EOP     4'b0011
`define SL3_CTRL_AM      4'b1100
`define SL3_CTRL_HALT    4'b0110

`endif

//--- logic/sl3_block_pkg.sv
// block format of the 66-bit lane words and the stream field types
// field positions count within the whole block, sync bits included
`include "sl3_rx_cfg.svh"

package sl3_block_pkg;

	// control type nibble, bits 37:34 of a control block
	typedef enum logic [3:0] {
		CTRL_IDLE = `SL3_CTRL_IDLE,
		CTRL_EOP  = `SL3_CTRL_EOP,
		CTRL_AM   = `SL3_CTRL_AM,
		CTRL_HALT = `SL3_CTRL_HALT
	} ctrl_code_e;

	// what a lane carries on one beat
	typedef enum logic [2:0] {
		BLK_DATA,
		BLK_IDLE,
		BLK_EOP,
		BLK_AM,
		BLK_HALT,
		BLK_BAD
	} blk_kind_e;

	typedef logic [`SL3_BLOCK_W-1:0]   block_t;
	typedef logic [`SL3_PAYLOAD_W-1:0] payload_t;
	typedef logic [47:0]               user_ctrl_t;
	typedef logic [7:0]                flow_ctrl_t;
	typedef logic [5:0]                vcid_t;
	typedef logic [1:0]                flit_type_t;

	// sync header values, bit 0 arrives first
	localparam logic [1:0] SYNC_DATA = 2'b10;
	localparam logic [1:0] SYNC_CTRL = 2'b01;

	function automatic payload_t blk_payload(block_t b);
		return b[65:2];
	endfunction

	function automatic ctrl_code_e blk_ctrl_code(block_t b);
		return ctrl_code_e'(b[37:34]);
	endfunction

	// fields present in every control block
	function automatic flow_ctrl_t blk_flow(block_t b);
		return b[65:58];
	endfunction

	// eop only
	function automatic flit_type_t blk_flit(block_t b);
		return b[57:56];
	endfunction

	function automatic vcid_t blk_vcid(block_t b);
		return b[55:50];
	endfunction

	function automatic logic [31:0] blk_eop_crc(block_t b);
		return b[33:2];
	endfunction

	// am only, split around the type nibble
	function automatic user_ctrl_t blk_user_ctrl(block_t b);
		return {b[57:42], b[33:2]};
	endfunction

endpackage

//--- logic/sl3_crc_pkg.sv
// crc-32 type and update, msb of the payload first
// no reflection and no final inversion
// one call covers one lane; a two-lane beat takes two calls, lane 0 first
`include "sl3_rx_cfg.svh"

package sl3_crc_pkg;

	typedef logic [31:0] crc_t;

	// advance the crc over one 64-bit lane payload
	function automatic crc_t crc32_step(crc_t crc_in, sl3_block_pkg::payload_t data);
		crc_t c;
		logic fb;
		c = crc_in;
		// bit serial form, unrolled by synthesis into an xor tree
		for (int i = `SL3_PAYLOAD_W - 1; i >= 0; i--) begin
			fb = c[31] ^ data[i];
			c = {c[30:0], 1'b0};
			if (fb) begin
				c = c ^ `SL3_CRC_POLY;
			end
		end
		return c;
	endfunction

endpackage

//--- logic/sl3_lane_if.sv
// one beat of classified lane blocks, decoder to checkers
// purely combinational, no handshake; sample whenever beat is high
`timescale 1ns/100ps
`include "sl3_rx_cfg.svh"

interface sl3_lane_if;
	import sl3_block_pkg::*;

	// rx_valid strobe
	logic      beat;
	// per lane classification
	blk_kind_e kind    [`SL3_LANES];
	// per lane payload with sync bits removed
	payload_t  payload [`SL3_LANES];
	// raw blocks, for field extraction downstream
	block_t    blk     [`SL3_LANES];

	modport src (
		output beat,
		output kind,
		output payload,
		output blk
	);

	modport snk (
		input beat,
		input kind,
		input payload,
		input blk
	);

endinterface

//--- logic/rx_block_decode.sv
// classifies each lane block and registers the packet stream
// one register stage from rx_valid/rx_dout to every output
// the lane interface is driven straight from the inputs
`timescale 1ns/100ps
`include "sl3_rx_cfg.svh"

module rx_block_decode (
	input  logic                                          rx_clk,
	input  logic                                          rx_srst,
	input  logic                                          rx_valid,
	input  sl3_block_pkg::block_t [`SL3_LANES-1:0]        rx_dout,
	sl3_lane_if.src                                       lanes,
	output logic                                          rx_tvalid,
	output logic                                          rx_tlast,
	output logic [`SL3_LANES*`SL3_KEEP_W-1:0]             rx_tkeep,
	output logic [`SL3_LANES*`SL3_PAYLOAD_W-1:0]          rx_tdata,
	output sl3_block_pkg::vcid_t                          rx_vcid,
	output sl3_block_pkg::flit_type_t                     rx_flit_type,
	output sl3_block_pkg::user_ctrl_t [`SL3_LANES-1:0]    rx_user_ctrl,
	output logic                                          rx_user_ctrl_valid
);
	import sl3_block_pkg::*;

	blk_kind_e             kind [`SL3_LANES];
	logic [`SL3_LANES-1:0] is_data;
	logic [`SL3_LANES-1:0] is_eop;
	logic [`SL3_LANES-1:0] is_am;

	//////////////////////////////////////////////////////////////////////
	// lane classification
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		lanes.beat = rx_valid;
		for (int i = 0; i < `SL3_LANES; i++) begin
			// sync header first, then the type nibble of control blocks
			if (rx_dout[i][1:0] == SYNC_DATA) begin
				kind[i] = BLK_DATA;
			end else if (rx_dout[i][1:0] == SYNC_CTRL) begin
				case (blk_ctrl_code(rx_dout[i]))
					CTRL_IDLE: kind[i] = BLK_IDLE;
					CTRL_EOP:  kind[i] = BLK_EOP;
					CTRL_AM:   kind[i] = BLK_AM;
					CTRL_HALT: kind[i] = BLK_HALT;
					default:   kind[i] = BLK_BAD;
				endcase
			end else begin
				// 00 and 11 are illegal sync headers
				kind[i] = BLK_BAD;
			end
			is_data[i] = rx_valid && (kind[i] == BLK_DATA);
			is_eop[i] = rx_valid && (kind[i] == BLK_EOP);
			is_am[i] = rx_valid && (kind[i] == BLK_AM);
			lanes.kind[i] = kind[i];
			lanes.payload[i] = blk_payload(rx_dout[i]);
			lanes.blk[i] = rx_dout[i];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stream registers
	//////////////////////////////////////////////////////////////////////

	// control side of the stream
	always_ff @(posedge rx_clk) begin
		if (rx_srst) begin
			rx_tvalid <= 1'b0;
			rx_tlast <= 1'b0;
			rx_tkeep <= '0;
			rx_user_ctrl_valid <= 1'b0;
			rx_vcid <= '0;
			rx_flit_type <= '0;
		end else begin
			// data or eop anywhere makes a stream beat
			rx_tvalid <= |(is_data | is_eop);
			rx_tlast <= |is_eop;
			rx_user_ctrl_valid <= |is_am;
			for (int i = 0; i < `SL3_LANES; i++) begin
				rx_tkeep[i*`SL3_KEEP_W +: `SL3_KEEP_W] <= {`SL3_KEEP_W{is_data[i]}};
			end
			// lane 1 wins when both lanes hold an eop
			if (is_eop[1]) begin
				rx_vcid <= blk_vcid(rx_dout[1]);
				rx_flit_type <= blk_flit(rx_dout[1]);
			end else if (is_eop[0]) begin
				rx_vcid <= blk_vcid(rx_dout[0]);
				rx_flit_type <= blk_flit(rx_dout[0]);
			end
		end
	end

	// payload side, zero for anything but data
	always_ff @(posedge rx_clk) begin
		for (int i = 0; i < `SL3_LANES; i++) begin
			rx_tdata[i*`SL3_PAYLOAD_W +: `SL3_PAYLOAD_W] <=
				is_data[i] ? blk_payload(rx_dout[i]) : '0;
			// user control holds its last value between am blocks
			if (is_am[i]) begin
				rx_user_ctrl[i] <= blk_user_ctrl(rx_dout[i]);
			end
		end
	end

	// end of packet is always a stream beat
	a_tlast_in_beat: assert property (@(posedge rx_clk) disable iff (rx_srst)
		rx_tlast |-> rx_tvalid);

endmodule

//--- logic/rx_link_monitor.sv
// flow control capture, error-free timer and halt state
// halt decisions need every lane to agree, as protection against bit errors
// resume needs 512 error-free cycles since reset or the last soft error
`timescale 1ns/100ps
`include "sl3_rx_cfg.svh"

module rx_link_monitor (
	input  logic                        rx_clk,
	input  logic                        rx_srst,
	sl3_lane_if.snk                     lanes,
	input  logic                        crc_error,
	output sl3_block_pkg::flow_ctrl_t   rx_flow_control,
	output logic                        rx_halted,
	output logic                        rx_soft_error
);
	import sl3_block_pkg::*;

	logic [`SL3_ERR_CNT_BITS-1:0] err_timer;
	logic                         stable;
	logic                         all_halt;
	logic                         all_am;
	logic                         all_halt_r;
	logic                         all_am_r;

	// flow control rides in the highest lane's control blocks
	always_ff @(posedge rx_clk) begin
		if (rx_srst) begin
			rx_flow_control <= '0;
		end else if (lanes.beat && (lanes.kind[`SL3_LANES-1] != BLK_DATA)) begin
			rx_flow_control <= blk_flow(lanes.blk[`SL3_LANES-1]);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// error-free timer
	//////////////////////////////////////////////////////////////////////

	assign stable = err_timer[`SL3_ERR_CNT_BITS-1];

	always_ff @(posedge rx_clk) begin
		if (rx_srst) begin
			rx_soft_error <= 1'b0;
			err_timer <= '0;
		end else begin
			rx_soft_error <= crc_error;
			// restart on each soft error, park once stable
			if (rx_soft_error) begin
				err_timer <= '0;
			end else if (!stable) begin
				err_timer <= err_timer + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// halt consensus
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		all_halt = lanes.beat;
		all_am = lanes.beat;
		for (int i = 0; i < `SL3_LANES; i++) begin
			all_halt = all_halt && (lanes.kind[i] == BLK_HALT);
			all_am = all_am && (lanes.kind[i] == BLK_AM);
		end
	end

	// first stage registers the vote, second updates the state
	always_ff @(posedge rx_clk) begin
		if (rx_srst) begin
			all_halt_r <= 1'b0;
			all_am_r <= 1'b0;
			rx_halted <= 1'b1;
		end else begin
			all_halt_r <= all_halt;
			all_am_r <= all_am;
			if (all_halt_r) begin
				rx_halted <= 1'b1;
			end else if (all_am_r && stable) begin
				rx_halted <= 1'b0;
			end
		end
	end

	// link comes out of reset halted
	a_halted_after_reset: assert property (@(posedge rx_clk)
		rx_srst |=> rx_halted);

endmodule

//--- logic/rx_crc_check.sv
// per-packet crc-32 over data payloads, lane 0 first
// expected value sits in the low 32 payload bits of the eop block
// result lands one cycle after the stream's tlast
`timescale 1ns/100ps
`include "sl3_rx_cfg.svh"

module rx_crc_check (
	input  logic    rx_clk,
	input  logic    rx_srst,
	sl3_lane_if.snk lanes,
	output logic    rx_crc_valid,
	output logic    crc_error
);
	import sl3_block_pkg::*;
	import sl3_crc_pkg::*;

	crc_t crc_q;
	crc_t crc_next;
	crc_t crc_exp;
	crc_t calc_r;
	crc_t expect_r;
	logic any_eop;
	logic eop_r;

	// fold this beat's data lanes and find the eop field
	always_comb begin
		crc_next = crc_q;
		crc_exp = '0;
		any_eop = 1'b0;
		for (int i = 0; i < `SL3_LANES; i++) begin
			if (lanes.kind[i] == BLK_DATA) begin
				crc_next = crc32_step(crc_next, lanes.payload[i]);
			end
			if (lanes.kind[i] == BLK_EOP) begin
				any_eop = lanes.beat;
				crc_exp = blk_eop_crc(lanes.blk[i]);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// running crc and compare
	//////////////////////////////////////////////////////////////////////

	// reseed after each eop so the next packet starts clean
	always_ff @(posedge rx_clk) begin
		if (rx_srst) begin
			crc_q <= `SL3_CRC_SEED;
			eop_r <= 1'b0;
			rx_crc_valid <= 1'b0;
			crc_error <= 1'b0;
		end else begin
			if (lanes.beat) begin
				crc_q <= any_eop ? `SL3_CRC_SEED : crc_next;
			end
			// eop_r lines up with rx_tlast
			eop_r <= any_eop;
			rx_crc_valid <= eop_r;
			crc_error <= eop_r && (calc_r != expect_r);
		end
	end

	// final and expected values, only meaningful with eop_r
	always_ff @(posedge rx_clk) begin
		if (any_eop) begin
			calc_r <= crc_next;
			expect_r <= crc_exp;
		end
	end

	// a mismatch is only reported on a checked packet
	a_err_with_valid: assert property (@(posedge rx_clk) disable iff (rx_srst)
		crc_error |-> rx_crc_valid);

endmodule

//--- logic/sl3_rx_top.sv
// receive coding layer for a two-lane 64b/66b link
// expects word-locked, deskewed blocks; rx_valid is a plain strobe
// no back-pressure, the stream must be taken whenever rx_tvalid is high
`timescale 1ns/100ps
`include "sl3_rx_cfg.svh"

module sl3_rx_top (
	input  logic                                          rx_clk,
	input  logic                                          rx_srst,
	input  logic                                          rx_valid,
	input  sl3_block_pkg::block_t [`SL3_LANES-1:0]        rx_dout,
	// packet stream
	output logic                                          rx_tvalid,
	output logic                                          rx_tlast,
	output logic [`SL3_LANES*`SL3_KEEP_W-1:0]             rx_tkeep,
	output logic [`SL3_LANES*`SL3_PAYLOAD_W-1:0]          rx_tdata,
	output sl3_block_pkg::vcid_t                          rx_vcid,
	output sl3_block_pkg::flit_type_t                     rx_flit_type,
	// in-band control
	output sl3_block_pkg::user_ctrl_t [`SL3_LANES-1:0]    rx_user_ctrl,
	output logic                                          rx_user_ctrl_valid,
	output sl3_block_pkg::flow_ctrl_t                     rx_flow_control,
	// link status
	output logic                                          rx_halted,
	output logic                                          rx_soft_error,
	output logic                                          rx_crc_valid,
	output logic                                          rx_crc_error
);

	// classified lane blocks shared by the checkers
	sl3_lane_if lanes_if ();

	rx_block_decode decode_i (
		.rx_clk             (rx_clk),
		.rx_srst            (rx_srst),
		.rx_valid           (rx_valid),
		.rx_dout            (rx_dout),
		.lanes              (lanes_if),
		.rx_tvalid          (rx_tvalid),
		.rx_tlast           (rx_tlast),
		.rx_tkeep           (rx_tkeep),
		.rx_tdata           (rx_tdata),
		.rx_vcid            (rx_vcid),
		.rx_flit_type       (rx_flit_type),
		.rx_user_ctrl       (rx_user_ctrl),
		.rx_user_ctrl_valid (rx_user_ctrl_valid)
	);

	// crc mismatch also feeds the soft error and timer restart
	rx_crc_check crc_i (
		.rx_clk       (rx_clk),
		.rx_srst      (rx_srst),
		.lanes        (lanes_if),
		.rx_crc_valid (rx_crc_valid),
		.crc_error    (rx_crc_error)
	);

	rx_link_monitor monitor_i (
		.rx_clk          (rx_clk),
		.rx_srst         (rx_srst),
		.lanes           (lanes_if),
		.crc_error       (rx_crc_error),
		.rx_flow_control (rx_flow_control),
		.rx_halted       (rx_halted),
		.rx_soft_error   (rx_soft_error)
	);

endmodule

//--- tests/tb_sl3_rx.sv
// directed testbench for the two-lane 64b/66b receive layer
// inputs change 2 ns after the rising edge and outputs are read at that point
// the crc model here works a 32-bit word at a time, msb first
// halt resume test runs over a thousand idle cycles
`timescale 1ns/100ps
`include "sl3_rx_cfg.svh"

module tb_sl3_rx;
	import sl3_block_pkg::*;

	logic                                   rx_clk;
	logic                                   rx_srst;
	logic                                   rx_valid;
	block_t [`SL3_LANES-1:0]                rx_dout;
	logic                                   rx_tvalid;
	logic                                   rx_tlast;
	logic [`SL3_LANES*`SL3_KEEP_W-1:0]      rx_tkeep;
	logic [`SL3_LANES*`SL3_PAYLOAD_W-1:0]   rx_tdata;
	vcid_t                                  rx_vcid;
	flit_type_t                             rx_flit_type;
	user_ctrl_t [`SL3_LANES-1:0]            rx_user_ctrl;
	logic                                   rx_user_ctrl_valid;
	flow_ctrl_t                             rx_flow_control;
	logic                                   rx_halted;
	logic                                   rx_soft_error;
	logic                                   rx_crc_valid;
	logic                                   rx_crc_error;

	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	logic [31:0] rng_state = 32'd21;

	sl3_rx_top dut_i (.*);

	initial begin
		rx_clk = 1'b0;
		forever #20 rx_clk = ~rx_clk;
	end

	// hard stop in case a loop never ends
	initial begin
		#200000;
		$display("timeout: the run did not finish within 200 us");
		$display("Simulation failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// xorshift32
	function automatic logic [31:0] rng_next();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic payload_t rand_payload();
		return {rng_next(), rng_next()};
	endfunction

	// word-wise crc-32 in the same bit order as the link
	function automatic logic [31:0] ref_crc64(logic [31:0] crc, payload_t d);
		logic [31:0] c;
		c = crc;
		for (int w = 1; w >= 0; w--) begin
			c = c ^ d[w*32 +: 32];
			for (int s = 0; s < 32; s++) begin
				c = c[31] ? ((c << 1) ^ 32'h04C11DB7) : (c << 1);
			end
		end
		return c;
	endfunction

	function automatic block_t data_block(payload_t p);
		return {p, 2'b10};
	endfunction

	// control layout is flow 65:58, mid 57:38, type 37:34, low 33:2, sync 01
	function automatic block_t ctrl_block(flow_ctrl_t fc, logic [3:0] code,
			logic [19:0] mid, logic [31:0] low);
		return {fc, mid, code, low, 2'b01};
	endfunction

	function automatic block_t idle_block(flow_ctrl_t fc);
		return ctrl_block(fc, `SL3_CTRL_IDLE, 20'h0, 32'h0);
	endfunction

	function automatic block_t halt_block(flow_ctrl_t fc);
		return ctrl_block(fc, `SL3_CTRL_HALT, 20'h0, 32'h0);
	endfunction

	function automatic block_t eop_block(flow_ctrl_t fc, flit_type_t ft, vcid_t vc,
			logic [31:0] crc);
		return ctrl_block(fc, `SL3_CTRL_EOP, {ft, vc, 12'h0}, crc);
	endfunction

	// user word split around the type nibble, bits 41:38 unused
	function automatic block_t am_block(flow_ctrl_t fc, user_ctrl_t uc);
		return ctrl_block(fc, `SL3_CTRL_AM, {uc[47:32], 4'h0}, uc[31:0]);
	endfunction

	// one beat in, then park rx_valid low; outputs for that beat are readable on return
	task automatic drive_beat(input logic v, input block_t b0, input block_t b1);
		rx_valid = v;
		rx_dout[0] = b0;
		rx_dout[1] = b1;
		@(posedge rx_clk);
		#2;
		rx_valid = 1'b0;
	endtask

	task automatic drive_idle_cycles(input int n);
		for (int k = 0; k < n; k++) begin
			drive_beat(1'b0, idle_block(8'h00), idle_block(8'h00));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_payload(input string name, input payload_t exp, input payload_t act);
		checks++;
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_user_ctrl(input string name, input user_ctrl_t exp,
			input user_ctrl_t act);
		checks++;
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flow(input string name, input flow_ctrl_t exp, input flow_ctrl_t act);
		checks++;
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_vcid(input string name, input vcid_t exp, input vcid_t act);
		checks++;
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flit(input string name, input flit_type_t exp, input flit_type_t act);
		checks++;
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			$display("ERR %s expected %b actual %b", name, exp, act);
			errors++;
		end
	endtask

	// stream view of the beat just driven
	task automatic check_stream(input string name, input logic [1:0] data_m,
			input logic [1:0] eop_m, input payload_t p0, input payload_t p1);
		logic [`SL3_KEEP_W-1:0] keep;
		logic                   keep_bit;
		check_bit({name, "_tvalid"}, |(data_m | eop_m), rx_tvalid);
		check_bit({name, "_tlast"}, |eop_m, rx_tlast);
		for (int i = 0; i < `SL3_LANES; i++) begin
			check_payload({name, "_tdata"}, data_m[i] ? ((i == 0) ? p0 : p1) : '0,
				rx_tdata[i*`SL3_PAYLOAD_W +: `SL3_PAYLOAD_W]);
			keep = rx_tkeep[i*`SL3_KEEP_W +: `SL3_KEEP_W];
			// anything but all ones or all zeros is never right
			keep_bit = (&keep) ? 1'b1 : ((|keep) ? 1'bx : 1'b0);
			check_bit({name, "_tkeep"}, data_m[i], keep_bit);
		end
	endtask

	task automatic report_test_end(input string name, input int err_start);
		tests_run++;
		$display("test %s done, %0d errors", name, errors - err_start);
	endtask

	// polls rx_halted with a bounded number of idle cycles
	task automatic wait_halted(input logic target, input int limit, output int taken);
		taken = 0;
		while (rx_halted !== target && taken < limit) begin
			drive_beat(1'b0, idle_block(8'h00), idle_block(8'h00));
			taken++;
		end
		if (rx_halted !== target) begin
			$display("rx_halted did not reach %b within %0d cycles", target, limit);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	// random data beats with optional gaps, then eop, crc result and soft error
	task automatic send_packet(input string name, input int nbeats, input int eop_lane,
			input logic corrupt);
		logic [31:0] crc;
		logic [31:0] field;
		logic [31:0] r;
		payload_t    p0;
		payload_t    p1;
		crc = 32'hFFFFFFFF;
		for (int n = 0; n < nbeats; n++) begin
			p0 = rand_payload();
			p1 = rand_payload();
			crc = ref_crc64(ref_crc64(crc, p0), p1);
			drive_beat(1'b1, data_block(p0), data_block(p1));
			check_stream(name, 2'b11, 2'b00, p0, p1);
			// a gap must not reach the stream or the crc
			if (rng_next() & 32'h1) begin
				drive_beat(1'b0, data_block(p1), data_block(p0));
				check_stream({name, "_gap"}, 2'b00, 2'b00, '0, '0);
			end
		end
		r = rng_next();
		if (eop_lane == 0) begin
			field = corrupt ? (crc ^ (32'h1 << r[12:8])) : crc;
			drive_beat(1'b1, eop_block(8'h00, r[7:6], r[5:0], field), idle_block(8'h00));
			check_stream({name, "_eop"}, 2'b00, 2'b01, '0, '0);
		end else begin
			p0 = rand_payload();
			crc = ref_crc64(crc, p0);
			field = corrupt ? (crc ^ (32'h1 << r[12:8])) : crc;
			drive_beat(1'b1, data_block(p0), eop_block(8'h00, r[7:6], r[5:0], field));
			check_stream({name, "_eop"}, 2'b01, 2'b10, p0, '0);
		end
		check_vcid({name, "_vcid"}, r[5:0], rx_vcid);
		check_flit({name, "_flit"}, r[7:6], rx_flit_type);
		check_bit({name, "_crc_valid_early"}, 1'b0, rx_crc_valid);
		drive_beat(1'b0, idle_block(8'h00), idle_block(8'h00));
		check_bit({name, "_crc_valid"}, 1'b1, rx_crc_valid);
		check_bit({name, "_crc_error"}, corrupt, rx_crc_error);
		check_bit({name, "_soft_early"}, 1'b0, rx_soft_error);
		drive_beat(1'b0, idle_block(8'h00), idle_block(8'h00));
		check_bit({name, "_crc_valid_end"}, 1'b0, rx_crc_valid);
		check_bit({name, "_soft_error"}, corrupt, rx_soft_error);
	endtask

	task automatic test_reset_state();
		int err0;
		err0 = errors;
		check_bit("reset_tvalid", 1'b0, rx_tvalid);
		check_bit("reset_tlast", 1'b0, rx_tlast);
		check_bit("reset_uc_valid", 1'b0, rx_user_ctrl_valid);
		check_bit("reset_crc_valid", 1'b0, rx_crc_valid);
		check_bit("reset_crc_error", 1'b0, rx_crc_error);
		check_bit("reset_soft_error", 1'b0, rx_soft_error);
		check_bit("reset_halted", 1'b1, rx_halted);
		check_flow("reset_flow", 8'h00, rx_flow_control);
		check_vcid("reset_vcid", 6'h00, rx_vcid);
		check_flit("reset_flit", 2'b00, rx_flit_type);
		report_test_end("reset_state", err0);
	endtask

	task automatic test_good_packets();
		int err0;
		err0 = errors;
		send_packet("good_a", 1 + int'(rng_next() % 5), 0, 1'b0);
		send_packet("good_b", 1 + int'(rng_next() % 5), 1, 1'b0);
		send_packet("good_c", 1 + int'(rng_next() % 5), 0, 1'b0);
		report_test_end("good_packets", err0);
	endtask

	task automatic test_crc_corrupt();
		int err0;
		err0 = errors;
		send_packet("bad_crc", 2, 1, 1'b1);
		report_test_end("crc_corrupt", err0);
	endtask

	task automatic test_alignment();
		int          err0;
		payload_t    p;
		logic [31:0] crc;
		user_ctrl_t  uc_a;
		user_ctrl_t  uc_b;
		user_ctrl_t  uc_c;
		err0 = errors;
		p = rand_payload();
		uc_a = p[47:0];
		p = rand_payload();
		uc_b = p[47:0];
		p = rand_payload();
		uc_c = p[47:0];
		drive_beat(1'b1, am_block(8'h11, uc_a), am_block(8'h5A, uc_b));
		check_user_ctrl("am_lane0", uc_a, rx_user_ctrl[0]);
		check_user_ctrl("am_lane1", uc_b, rx_user_ctrl[1]);
		check_bit("am_valid", 1'b1, rx_user_ctrl_valid);
		check_bit("am_tvalid", 1'b0, rx_tvalid);
		check_flow("am_flow", 8'h5A, rx_flow_control);
		// not a beat, so nothing moves
		drive_beat(1'b0, am_block(8'h22, uc_c), am_block(8'h33, uc_c));
		check_user_ctrl("am_hold0", uc_a, rx_user_ctrl[0]);
		check_user_ctrl("am_hold1", uc_b, rx_user_ctrl[1]);
		check_bit("am_valid_pulse", 1'b0, rx_user_ctrl_valid);
		check_flow("am_flow_hold", 8'h5A, rx_flow_control);
		// lane 0 control carries no flow control
		p = rand_payload();
		drive_beat(1'b1, am_block(8'hC3, uc_c), data_block(p));
		check_user_ctrl("am_new0", uc_c, rx_user_ctrl[0]);
		check_user_ctrl("am_keep1", uc_b, rx_user_ctrl[1]);
		check_bit("am_valid_again", 1'b1, rx_user_ctrl_valid);
		check_flow("am_flow_lane0", 8'h5A, rx_flow_control);
		check_stream("am_data", 2'b10, 2'b00, '0, p);
		// close the one-beat packet so the crc reseeds
		crc = ref_crc64(32'hFFFFFFFF, p);
		drive_beat(1'b1, eop_block(8'h00, 2'b01, 6'h2A, crc), idle_block(8'h77));
		check_flow("am_flow_idle", 8'h77, rx_flow_control);
		check_bit("am_valid_off", 1'b0, rx_user_ctrl_valid);
		check_user_ctrl("am_hold_eop", uc_c, rx_user_ctrl[0]);
		check_bit("am_eop_tlast", 1'b1, rx_tlast);
		drive_beat(1'b0, idle_block(8'h00), idle_block(8'h00));
		check_bit("am_crc_valid", 1'b1, rx_crc_valid);
		check_bit("am_crc_error", 1'b0, rx_crc_error);
		report_test_end("alignment", err0);
	endtask

	task automatic test_halt_resume();
		int err0;
		int taken;
		err0 = errors;
		// let the timer from reset expire so that only the soft error holds the halt
		drive_idle_cycles(520);
		check_bit("halt_before_err", 1'b1, rx_halted);
		// fresh soft error restarts the error-free timer
		send_packet("halt_err", 1, 0, 1'b1);
		drive_beat(1'b1, am_block(8'h00, 48'h0), am_block(8'h00, 48'h0));
		drive_idle_cycles(2);
		check_bit("halt_hold_unstable", 1'b1, rx_halted);
		// still a few cycles short of 512 since the soft error
		drive_idle_cycles(495);
		drive_beat(1'b1, am_block(8'h00, 48'h3), am_block(8'h00, 48'h4));
		drive_idle_cycles(2);
		check_bit("halt_hold_near_stable", 1'b1, rx_halted);
		drive_idle_cycles(20);
		drive_beat(1'b1, am_block(8'h00, 48'h1), am_block(8'h00, 48'h2));
		wait_halted(1'b0, 8, taken);
		check_bit("halt_clear_latency", 1'b1, taken == 1);
		drive_beat(1'b1, halt_block(8'h00), halt_block(8'h00));
		wait_halted(1'b1, 8, taken);
		check_bit("halt_set_latency", 1'b1, taken == 1);
		report_test_end("halt_resume", err0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rx_srst = 1'b1;
		rx_valid = 1'b0;
		rx_dout = '0;
		repeat (5) @(posedge rx_clk);
		#2;
		rx_srst = 1'b0;
		test_reset_state();
		test_good_packets();
		test_crc_corrupt();
		test_alignment();
		test_halt_resume();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+include
logic/sl3_block_pkg.sv
logic/sl3_crc_pkg.sv
logic/sl3_lane_if.sv
logic/rx_block_decode.sv
logic/rx_link_monitor.sv
logic/rx_crc_check.sv
logic/sl3_rx_top.sv
tests/tb_sl3_rx.sv

//--- run_sim.sh
#!/bin/sh
# build and run the receive layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_sl3_rx -o sim_tb_sl3_rx

out=$(./obj_dir/sim_tb_sl3_rx)
echo "$out"
echo "$out" | grep -q "Simulation passed"
